// ==== source/dcache_types_pkg.sv ====
package dcache_types_pkg;

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // way number inside a set
    typedef logic way_t;

    // byte offset bits of an address, always zero for word accesses
    localparam int BYTE_OFF_W = 2;

    // block geometry
    localparam int BLOCK_WORDS = 2;
    localparam int WAYS = 2;

endpackage

// ==== source/dcache_ctrl_pkg.sv ====
package dcache_ctrl_pkg;

    // controller states
    // the WB states carry a dirty victim out before a refill,
    // the FLUSH states walk the whole cache on halt
    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        FETCH1,
        FETCH2,
        FLUSH_SCAN,
        FLUSH_WB1,
        FLUSH_WB2,
        FLUSHED
    } cache_state_t;

endpackage

// ==== source/dcache_arrays.sv ====
`timescale 1ns/1ps

module dcache_arrays
    import dcache_types_pkg::*;
#(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - 1 - BYTE_OFF_W
) (
    input  logic             CLK,
    input  logic             nRST,

    // read side, one set at a time
    input  logic [IDX_W-1:0] idx,
    output logic [WAYS-1:0]  way_valid,
    output logic [WAYS-1:0]  way_dirty,
    output logic [TAG_W-1:0] way_tag0,
    output logic [TAG_W-1:0] way_tag1,
    output word_t            way0_word0,
    output word_t            way0_word1,
    output word_t            way1_word0,
    output word_t            way1_word1,
    output logic             lru,

    // single word write
    input  logic             wr_en,
    input  way_t             wr_way,
    input  logic             wr_word,
    input  word_t            wr_data,
    input  logic             wr_dirty,

    // tag fill into wr_way
    input  logic             fill_en,
    input  logic [TAG_W-1:0] fill_tag,

    // lru update
    input  logic             touch_en,
    input  way_t             touch_way,

    input  logic             clear_all
);

    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;
    logic [TAG_W-1:0]          tag_q [WAYS][SETS];
    word_t                     data_q [WAYS][SETS][BLOCK_WORDS];

    // one bit per set, names the way to replace next
    logic [SETS-1:0]           lru_q;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_valid[w] = valid_q[w][idx];
            way_dirty[w] = dirty_q[w][idx];
        end
    end

    assign way_tag0   = tag_q[0][idx];
    assign way_tag1   = tag_q[1][idx];
    assign way0_word0 = data_q[0][idx][0];
    assign way0_word1 = data_q[0][idx][1];
    assign way1_word0 = data_q[1][idx][0];
    assign way1_word1 = data_q[1][idx][1];
    assign lru        = lru_q[idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    tag_q[w][s] <= '0;
                    for (int b = 0; b < BLOCK_WORDS; b++) begin
                        data_q[w][s][b] <= '0;
                    end
                end
            end
        end else if (clear_all) begin
            // end of flush, data and tags may stay
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (wr_en) begin
                data_q[wr_way][idx][wr_word] <= wr_data;
                dirty_q[wr_way][idx]         <= wr_dirty;
            end
            if (fill_en) begin
                tag_q[wr_way][idx]   <= fill_tag;
                valid_q[wr_way][idx] <= 1'b1;
            end
            if (touch_en) begin
                // the other way becomes the victim
                lru_q[idx] <= ~touch_way;
            end
        end
    end

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_types_pkg::*;
    import dcache_ctrl_pkg::*;
#(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - 1 - BYTE_OFF_W
) (
    input  logic             CLK,
    input  logic             nRST,

    // processor side
    input  logic             dmemREN,
    input  logic             dmemWEN,
    input  word_t            dmemaddr,
    input  word_t            dmemstore,
    input  logic             halt,
    output logic             dhit,
    output word_t            dmemload,
    output logic             flushed,

    // memory side
    output logic             dREN,
    output logic             dWEN,
    output word_t            daddr,
    output word_t            dstore,
    input  word_t            dload,
    input  logic             dwait,

    // storage
    output logic [IDX_W-1:0] idx,
    input  logic [WAYS-1:0]  way_valid,
    input  logic [WAYS-1:0]  way_dirty,
    input  logic [TAG_W-1:0] way_tag0,
    input  logic [TAG_W-1:0] way_tag1,
    input  word_t            way0_word0,
    input  word_t            way0_word1,
    input  word_t            way1_word0,
    input  word_t            way1_word1,
    input  logic             lru,
    output logic             wr_en,
    output way_t             wr_way,
    output logic             wr_word,
    output word_t            wr_data,
    output logic             wr_dirty,
    output logic             fill_en,
    output logic [TAG_W-1:0] fill_tag,
    output logic             touch_en,
    output way_t             touch_way,
    output logic             clear_all
);

    cache_state_t     state;
    cache_state_t     next_state;
    logic [IDX_W-1:0] flush_set_q;
    logic [IDX_W-1:0] flush_set_n;
    way_t             flush_way_q;
    way_t             flush_way_n;

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic             req_word;
    logic             req;
    logic             hit0;
    logic             hit1;
    logic             hit;
    way_t             hit_way;

    // way being written back: lru victim, or the flush walk position
    logic             in_flush;
    way_t             sel_way;
    logic             sel_dirty;
    logic [TAG_W-1:0] sel_tag;
    word_t            sel_w0;
    word_t            sel_w1;

    // tag | index | block offset | byte offset
    assign req_tag  = dmemaddr[31 -: TAG_W];
    assign req_idx  = dmemaddr[BYTE_OFF_W + 1 +: IDX_W];
    assign req_word = dmemaddr[BYTE_OFF_W];
    assign req      = dmemREN | dmemWEN;

    assign in_flush = (state == FLUSH_SCAN) || (state == FLUSH_WB1) ||
                      (state == FLUSH_WB2) || (state == FLUSHED);
    assign idx      = in_flush ? flush_set_q : req_idx;

    assign hit0    = way_valid[0] && (way_tag0 == req_tag);
    assign hit1    = way_valid[1] && (way_tag1 == req_tag);
    assign hit     = hit0 | hit1;
    assign hit_way = hit1;

    always_comb begin
        if (hit_way) begin
            dmemload = req_word ? way1_word1 : way1_word0;
        end else begin
            dmemload = req_word ? way0_word1 : way0_word0;
        end
    end

    assign sel_way   = in_flush ? flush_way_q : lru;
    assign sel_dirty = way_dirty[sel_way];
    assign sel_tag   = sel_way ? way_tag1 : way_tag0;
    assign sel_w0    = sel_way ? way1_word0 : way0_word0;
    assign sel_w1    = sel_way ? way1_word1 : way0_word1;

    always_comb begin
        next_state  = state;
        flush_set_n = flush_set_q;
        flush_way_n = flush_way_q;
        dhit        = 1'b0;
        flushed     = 1'b0;
        dREN        = 1'b0;
        dWEN        = 1'b0;
        daddr       = '0;
        dstore      = '0;
        wr_en       = 1'b0;
        wr_way      = sel_way;
        wr_word     = 1'b0;
        wr_data     = dload;
        wr_dirty    = 1'b0;
        fill_en     = 1'b0;
        fill_tag    = req_tag;
        touch_en    = 1'b0;
        touch_way   = hit_way;
        clear_all   = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state  = FLUSH_SCAN;
                    flush_set_n = '0;
                    flush_way_n = 1'b0;
                end else if (req && hit) begin
                    dhit     = 1'b1;
                    touch_en = 1'b1;
                    if (dmemWEN) begin
                        wr_en    = 1'b1;
                        wr_way   = hit_way;
                        wr_word  = req_word;
                        wr_data  = dmemstore;
                        wr_dirty = 1'b1;
                    end
                end else if (req) begin
                    next_state = sel_dirty ? WB1 : FETCH1;
                end
            end

            // victim or flushed block, first word
            WB1, FLUSH_WB1: begin
                dWEN   = 1'b1;
                daddr  = {sel_tag, idx, 1'b0, BYTE_OFF_W'(0)};
                dstore = sel_w0;
                if (!dwait) begin
                    next_state = (state == WB1) ? WB2 : FLUSH_WB2;
                end
            end

            // second word, block is clean afterwards
            WB2, FLUSH_WB2: begin
                dWEN   = 1'b1;
                daddr  = {sel_tag, idx, 1'b1, BYTE_OFF_W'(0)};
                dstore = sel_w1;
                if (!dwait) begin
                    wr_en      = 1'b1;
                    wr_word    = 1'b1;
                    wr_data    = sel_w1;
                    next_state = (state == WB2) ? FETCH1 : FLUSH_SCAN;
                end
            end

            FETCH1: begin
                dREN  = 1'b1;
                daddr = {req_tag, idx, 1'b0, BYTE_OFF_W'(0)};
                if (!dwait) begin
                    wr_en      = 1'b1;
                    next_state = FETCH2;
                end
            end

            // tag goes in with the last word
            FETCH2: begin
                dREN  = 1'b1;
                daddr = {req_tag, idx, 1'b1, BYTE_OFF_W'(0)};
                if (!dwait) begin
                    wr_en      = 1'b1;
                    wr_word    = 1'b1;
                    fill_en    = 1'b1;
                    next_state = IDLE;
                end
            end

            FLUSH_SCAN: begin
                if (sel_dirty) begin
                    next_state = FLUSH_WB1;
                end else if (flush_way_q == 1'b0) begin
                    flush_way_n = 1'b1;
                end else if (flush_set_q == IDX_W'(SETS - 1)) begin
                    clear_all  = 1'b1;
                    next_state = FLUSHED;
                end else begin
                    flush_way_n = 1'b0;
                    flush_set_n = flush_set_q + 1'b1;
                end
            end

            // held until reset
            FLUSHED: begin
                flushed = 1'b1;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE;
            flush_set_q <= '0;
            flush_way_q <= 1'b0;
        end else begin
            state       <= next_state;
            flush_set_q <= flush_set_n;
            flush_way_q <= flush_way_n;
        end
    end

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/1ps

module dcache
    import dcache_types_pkg::*;
#(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - 1 - BYTE_OFF_W
) (
    input  logic  CLK,
    input  logic  nRST,

    // processor data port
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  logic  halt,
    output logic  dhit,
    output word_t dmemload,
    output logic  flushed,

    // memory bus
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);

    logic [IDX_W-1:0] idx;
    logic [WAYS-1:0]  way_valid;
    logic [WAYS-1:0]  way_dirty;
    logic [TAG_W-1:0] way_tag0;
    logic [TAG_W-1:0] way_tag1;
    word_t            way0_word0;
    word_t            way0_word1;
    word_t            way1_word0;
    word_t            way1_word1;
    logic             lru;
    logic             wr_en;
    way_t             wr_way;
    logic             wr_word;
    word_t            wr_data;
    logic             wr_dirty;
    logic             fill_en;
    logic [TAG_W-1:0] fill_tag;
    logic             touch_en;
    way_t             touch_way;
    logic             clear_all;

    dcache_ctrl #(
        .SETS(SETS)
    ) u_ctrl (
        .CLK(CLK),
        .nRST(nRST),
        .dmemREN(dmemREN),
        .dmemWEN(dmemWEN),
        .dmemaddr(dmemaddr),
        .dmemstore(dmemstore),
        .halt(halt),
        .dhit(dhit),
        .dmemload(dmemload),
        .flushed(flushed),
        .dREN(dREN),
        .dWEN(dWEN),
        .daddr(daddr),
        .dstore(dstore),
        .dload(dload),
        .dwait(dwait),
        .idx(idx),
        .way_valid(way_valid),
        .way_dirty(way_dirty),
        .way_tag0(way_tag0),
        .way_tag1(way_tag1),
        .way0_word0(way0_word0),
        .way0_word1(way0_word1),
        .way1_word0(way1_word0),
        .way1_word1(way1_word1),
        .lru(lru),
        .wr_en(wr_en),
        .wr_way(wr_way),
        .wr_word(wr_word),
        .wr_data(wr_data),
        .wr_dirty(wr_dirty),
        .fill_en(fill_en),
        .fill_tag(fill_tag),
        .touch_en(touch_en),
        .touch_way(touch_way),
        .clear_all(clear_all)
    );

    dcache_arrays #(
        .SETS(SETS)
    ) u_arrays (
        .CLK(CLK),
        .nRST(nRST),
        .idx(idx),
        .way_valid(way_valid),
        .way_dirty(way_dirty),
        .way_tag0(way_tag0),
        .way_tag1(way_tag1),
        .way0_word0(way0_word0),
        .way0_word1(way0_word1),
        .way1_word0(way1_word0),
        .way1_word1(way1_word1),
        .lru(lru),
        .wr_en(wr_en),
        .wr_way(wr_way),
        .wr_word(wr_word),
        .wr_data(wr_data),
        .wr_dirty(wr_dirty),
        .fill_en(fill_en),
        .fill_tag(fill_tag),
        .touch_en(touch_en),
        .touch_way(touch_way),
        .clear_all(clear_all)
    );

endmodule

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import dcache_types_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int SETS         = 8;
    localparam int NUM_TAGS     = 4;
    localparam int NUM_OPS      = 3000;
    localparam int MAX_CYCLES   = NUM_OPS * 40;

    logic  CLK;
    logic  nRST;
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
    logic  halt;
    logic  dhit;
    word_t dmemload;
    logic  flushed;
    logic  dREN;
    logic  dWEN;
    word_t daddr;
    word_t dstore;
    word_t dload;
    logic  dwait;

    // memory contents and the value the processor expects at each word
    word_t mem_model [word_t];
    word_t shadow [word_t];
    int    cycle_count;
    logic  wb_second;
    word_t wb_addr;

    dcache #(
        .SETS(SETS)
    ) DUT (
        .CLK(CLK),
        .nRST(nRST),
        .dmemREN(dmemREN),
        .dmemWEN(dmemWEN),
        .dmemaddr(dmemaddr),
        .dmemstore(dmemstore),
        .halt(halt),
        .dhit(dhit),
        .dmemload(dmemload),
        .flushed(flushed),
        .dREN(dREN),
        .dWEN(dWEN),
        .daddr(daddr),
        .dstore(dstore),
        .dload(dload),
        .dwait(dwait)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic stop_on_error();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    // tag above the set index, then block offset, then zero byte offset
    function automatic word_t make_addr(input int tag, input int set, input int word);
        return word_t'(((tag * SETS + set) * BLOCK_WORDS + word) * 4);
    endfunction

    task automatic check_quiet_outputs();
        check_value("dhit", dhit, 1'b0);
        check_value("dREN", dREN, 1'b0);
        check_value("dWEN", dWEN, 1'b0);
        check_value("flushed", flushed, 1'b0);
    endtask

    // falling edge: count, then answer the bus for the coming rising edge
    task automatic next_cycle();
        logic stall;
        @(negedge CLK);
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests not finished after %0d cycles", cycle_count);
            stop_on_error();
        end
        stall = 1'b0;
        if (dREN || dWEN) begin
            stall = ($urandom % 3) == 0;
            if (!mem_model.exists(daddr)) begin
                $display("bus access at %0t to address %h outside the memory", $time, daddr);
                stop_on_error();
            end
        end
        dwait = stall;
        dload = $urandom;
        if (dREN && !stall) begin
            dload = mem_model[daddr];
        end
        if (dWEN && !stall) begin
            check_value("dstore", dstore, shadow[daddr]);
            // write-backs come as word 0 then word 1 of one block
            if (!wb_second) begin
                check_value("daddr block offset", daddr[BYTE_OFF_W], 1'b0);
                wb_addr = daddr;
            end else begin
                check_value("daddr", daddr, wb_addr + 4);
            end
            wb_second = ~wb_second;
            mem_model[daddr] = dstore;
        end
    endtask

    task automatic access(input logic wr, input word_t addr, input word_t data,
                          output int cycles, output logic saw_ren, output logic saw_bus);
        logic done;
        dmemREN   = ~wr;
        dmemWEN   = wr;
        dmemaddr  = addr;
        dmemstore = data;
        done      = 1'b0;
        cycles    = 0;
        saw_ren   = 1'b0;
        saw_bus   = 1'b0;
        while (!done) begin
            // sample just before the rising edge
            #(CLK_PERIOD / 2 - 1);
            cycles++;
            saw_ren = saw_ren | dREN;
            saw_bus = saw_bus | dREN | dWEN;
            if (dhit) begin
                done = 1'b1;
                if (!wr) begin
                    check_value($sformatf("dmemload at %h", addr), dmemload, shadow[addr]);
                end
            end
            next_cycle();
        end
        if (wr) begin
            shadow[addr] = data;
        end
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
    endtask

    initial begin
        int    cycles;
        logic  saw_ren;
        logic  saw_bus;
        logic  wr;
        logic  have_prev;
        logic  done;
        word_t addr;
        word_t prev_addr;

        nRST        = 1'b0;
        dmemREN     = 1'b0;
        dmemWEN     = 1'b0;
        dmemaddr    = '0;
        dmemstore   = '0;
        halt        = 1'b0;
        dload       = '0;
        dwait       = 1'b0;
        cycle_count = 0;
        wb_second   = 1'b0;
        wb_addr     = '0;
        void'($urandom(32'hfe3e));

        // unwritten words hold their own address
        for (int t = 0; t < NUM_TAGS; t++) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < BLOCK_WORDS; w++) begin
                    mem_model[make_addr(t, s, w)] = make_addr(t, s, w);
                    shadow[make_addr(t, s, w)]    = make_addr(t, s, w);
                end
            end
        end

        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_quiet_outputs();
        end
        nRST = 1'b1;
        next_cycle();
        check_quiet_outputs();

        // random traffic, a quarter of it repeats the last address
        have_prev = 1'b0;
        prev_addr = '0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (have_prev && ($urandom % 4) == 0) begin
                addr = prev_addr;
            end else begin
                addr = make_addr($urandom % NUM_TAGS, $urandom % SETS, $urandom % BLOCK_WORDS);
            end
            wr = $urandom % 2;
            access(wr, addr, $urandom, cycles, saw_ren, saw_bus);
            if (have_prev && addr == prev_addr) begin
                check_value("cycles to dhit on repeat", cycles, 1);
                check_value("bus use on repeat", saw_bus, 1'b0);
            end
            prev_addr = addr;
            have_prev = 1'b1;
        end

        // set 5 with tags A=0, B=1, C=2
        access(1'b0, make_addr(0, 5, 0), '0, cycles, saw_ren, saw_bus);
        access(1'b0, make_addr(1, 5, 0), '0, cycles, saw_ren, saw_bus);
        access(1'b0, make_addr(0, 5, 0), '0, cycles, saw_ren, saw_bus);
        access(1'b0, make_addr(2, 5, 0), '0, cycles, saw_ren, saw_bus);
        access(1'b0, make_addr(0, 5, 0), '0, cycles, saw_ren, saw_bus);
        check_value("cycles to dhit for A", cycles, 1);
        access(1'b0, make_addr(1, 5, 0), '0, cycles, saw_ren, saw_bus);
        check_value("dREN before dhit for B", saw_ren, 1'b1);

        halt = 1'b1;
        done = 1'b0;
        while (!done) begin
            #(CLK_PERIOD / 2 - 1);
            check_value("dREN during flush", dREN, 1'b0);
            done = flushed;
            next_cycle();
        end
        repeat (16) begin
            #(CLK_PERIOD / 2 - 1);
            check_value("flushed", flushed, 1'b1);
            check_value("dWEN after flush", dWEN, 1'b0);
            next_cycle();
        end
        check_value("write-back pairs complete", wb_second, 1'b0);

        for (int t = 0; t < NUM_TAGS; t++) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < BLOCK_WORDS; w++) begin
                    addr = make_addr(t, s, w);
                    check_value($sformatf("memory at %h", addr), mem_model[addr], shadow[addr]);
                end
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
source/dcache_types_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_arrays.sv
source/dcache_ctrl.sv
source/dcache.sv
verification/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - source/dcache_types_pkg.sv
  - source/dcache_ctrl_pkg.sv
  - source/dcache_arrays.sv
  - source/dcache_ctrl.sv
  - source/dcache.sv
  - target: simulation
    files:
      - verification/tb_dcache.sv
